//--- Bender.yml
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - pipe_reg.sv
  - fetch_stage.sv
  - register_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - mips_core.sv
  - target: test
    files:
      - tb_mips_core.sv

//--- all.f
mips_pkg.sv
pipe_reg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
mips_core.sv
tb_mips_core.sv

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage import mips_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  if_id_t   i_inst,
    input  reg_idx_t i_ex_dest,             // Destination of op in execute
    input  logic     i_ex_reg_write,
    input  ex_wb_t   i_wb,
    input  reg_idx_t i_dbg_addr,
    output word_t    o_dbg_data,
    output id_ex_t   o_issue,
    output logic     o_pc_src,
    output word_t    o_target,
    output logic     o_stall
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      rf_a;
    word_t      rf_b;
    word_t      op_a;
    word_t      op_b;
    alu_op_e    alu_op;
    logic       use_imm;
    logic       zext;
    logic       reg_write;
    logic       use_rt;                     // Destination is rt
    logic       is_beq;
    logic       is_bne;
    logic       is_j;
    logic       taken;

    assign opcode   = i_inst.inst[31:26];
    assign rs       = i_inst.inst[25:21];
    assign rt       = i_inst.inst[20:16];
    assign rd       = i_inst.inst[15:11];
    assign funct    = i_inst.inst[5:0];
    assign imm_sext = {{16{i_inst.inst[15]}}, i_inst.inst[15:0]};
    assign imm_zext = {16'h0000, i_inst.inst[15:0]};

    register_file u_regs (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_we       (i_wb.valid && i_wb.reg_write),
        .i_waddr    (i_wb.dest),
        .i_wdata    (i_wb.result),
        .i_raddr_a  (rs),
        .i_raddr_b  (rt),
        .i_dbg_addr (i_dbg_addr),
        .o_rdata_a  (rf_a),
        .o_rdata_b  (rf_b),
        .o_dbg_data (o_dbg_data)
    );

    // Write-back lands at the end of this cycle, so bypass the file
    assign op_a = (i_wb.valid && i_wb.reg_write && i_wb.dest != '0 && i_wb.dest == rs)
                  ? i_wb.result : rf_a;
    assign op_b = (i_wb.valid && i_wb.reg_write && i_wb.dest != '0 && i_wb.dest == rt)
                  ? i_wb.result : rf_b;

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        zext      = 1'b0;
        reg_write = 1'b0;
        use_rt    = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0;  // Unsupported funct is a nop
                endcase
            end
            OP_ADDIU: begin
                alu_op    = ALU_ADD;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                use_rt    = 1'b1;
            end
            OP_ANDI: begin
                alu_op    = ALU_AND;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                use_rt    = 1'b1;
                zext      = 1'b1;
            end
            OP_ORI: begin
                alu_op    = ALU_OR;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                use_rt    = 1'b1;
                zext      = 1'b1;
            end
            OP_LUI: begin
                alu_op    = ALU_LUI;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                use_rt    = 1'b1;
            end
            OP_BEQ:   is_beq = 1'b1;
            OP_BNE:   is_bne = 1'b1;
            OP_J:     is_j = 1'b1;
            default: ;
        endcase
    end

    // Branch needs the value the op in execute is about to produce
    assign o_stall = i_inst.valid && (is_beq || is_bne) && i_ex_reg_write &&
                     (i_ex_dest != '0) && ((i_ex_dest == rs) || (i_ex_dest == rt));

    assign taken    = (is_beq && (op_a == op_b)) || (is_bne && (op_a != op_b));
    assign o_pc_src = i_inst.valid && !o_stall && (taken || is_j);
    assign o_target = is_j ? {i_inst.npc[31:28], i_inst.inst[25:0], 2'b00}
                           : i_inst.npc + (imm_sext << 2);

    assign o_issue = '{
        valid:     i_inst.valid,
        alu_op:    alu_op,
        src_a:     rs,
        op_a:      op_a,
        src_b:     rt,
        op_b:      op_b,
        use_imm:   use_imm,
        imm:       zext ? imm_zext : imm_sext,
        reg_write: i_inst.valid && reg_write,
        dest:      use_rt ? rt : rd
    };

    // After one bubble the producer sits in ex_wb and is forwarded
    a_stall_one_cycle : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_stall |=> !o_stall
    );

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage import mips_pkg::*; (
    input  id_ex_t i_op,
    input  ex_wb_t i_wb,                    // Result of the previous op
    output ex_wb_t o_res
);

    logic  fwd_a;
    logic  fwd_b;
    word_t a;
    word_t b_reg;
    word_t b;
    word_t result;

    assign fwd_a = i_wb.valid && i_wb.reg_write && (i_wb.dest != '0) &&
                   (i_wb.dest == i_op.src_a);
    assign fwd_b = i_wb.valid && i_wb.reg_write && (i_wb.dest != '0) &&
                   (i_wb.dest == i_op.src_b);

    assign a     = fwd_a ? i_wb.result : i_op.op_a;
    assign b_reg = fwd_b ? i_wb.result : i_op.op_b;
    assign b     = i_op.use_imm ? i_op.imm : b_reg;

    always_comb begin
        case (i_op.alu_op)
            ALU_ADD: result = a + b;        // Wraps, no overflow trap
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign o_res = '{
        valid:     i_op.valid,
        reg_write: i_op.valid && i_op.reg_write,
        dest:      i_op.dest,
        result:    result
    };

    always_comb begin
        if (i_op.valid) begin
            a_alu_op_known : assert final (!$isunknown(i_op.alu_op) && i_op.alu_op <= ALU_LUI);
        end
    end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage import mips_pkg::*; (
    input  logic    i_clk,
    input  logic    i_arst_n,
    input  logic    i_stall,
    input  logic    i_pc_src,
    input  word_t   i_target,
    input  wb_s2m_t i_wb,
    output wb_m2s_t o_wb,
    output if_id_t  o_inst
);

    word_t  pc;                             // Next address to fetch
    logic   pend_valid;                     // Redirect waits for delay slot ack
    word_t  pend_target;
    if_id_t held_q;                         // Fetched while decode stalls
    if_id_t fetched;
    logic   fetch_done;
    logic   ds_fetched;
    logic   redirect;
    word_t  redirect_pc;

    assign fetch_done  = o_wb.stb && i_wb.ack;
    assign ds_fetched  = !o_wb.cyc && held_q.valid;  // Delay slot already in hand
    assign redirect    = i_pc_src || pend_valid;
    assign redirect_pc = i_pc_src ? i_target : pend_target;

    assign fetched = '{valid: fetch_done, inst: i_wb.dat, npc: o_wb.adr + 32'd4};
    assign o_inst  = held_q.valid ? held_q : fetched;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb        <= '0;
            pc          <= RESET_PC;
            pend_valid  <= 1'b0;
            pend_target <= '0;
            held_q      <= '0;
        end else begin
            if (!i_stall) begin
                held_q.valid <= 1'b0;       // Consumed by if_id
            end
            if (fetch_done) begin
                o_wb.cyc   <= 1'b0;         // Idle at least one cycle
                o_wb.stb   <= 1'b0;
                pc         <= redirect ? redirect_pc : o_wb.adr + 32'd4;
                pend_valid <= 1'b0;
                if (i_stall) begin
                    held_q <= fetched;
                end
            end else begin
                if (i_pc_src && !ds_fetched) begin
                    pend_valid  <= 1'b1;
                    pend_target <= i_target;
                end
                if (!o_wb.cyc && !i_stall) begin
                    o_wb.cyc <= 1'b1;
                    o_wb.stb <= 1'b1;
                    o_wb.adr <= (i_pc_src && ds_fetched) ? i_target : pc;
                end
            end
        end
    end

    a_stb_in_cyc : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_wb.stb |-> o_wb.cyc
    );

    a_adr_stable : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_wb.stb && !i_wb.ack |=> $stable(o_wb.adr)
    );

endmodule

//--- mips_core.sv
`timescale 1ns/1ns

module mips_core import mips_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  wb_s2m_t  i_wb,
    output wb_m2s_t  o_wb,
    input  reg_idx_t i_dbg_addr,
    output word_t    o_dbg_data
);

    if_id_t if_d;
    if_id_t if_q;
    id_ex_t id_d;
    id_ex_t id_q;
    ex_wb_t ex_d;
    ex_wb_t ex_q;
    logic   stall;
    logic   pc_src;
    word_t  target;

    fetch_stage u_fetch (
        .i_clk, .i_arst_n,
        .i_stall  (stall),
        .i_pc_src (pc_src),
        .i_target (target),
        .i_wb     (i_wb),
        .o_wb     (o_wb),
        .o_inst   (if_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .i_clk, .i_arst_n, .i_hold(stall), .i_bubble(1'b0), .i_d(if_d), .o_q(if_q)
    );

    decode_stage u_decode (
        .i_clk, .i_arst_n,
        .i_inst         (if_q),
        .i_ex_dest      (id_q.dest),
        .i_ex_reg_write (id_q.reg_write),     // Zero for bubbles
        .i_wb           (ex_q),
        .i_dbg_addr     (i_dbg_addr),
        .o_dbg_data     (o_dbg_data),
        .o_issue        (id_d),
        .o_pc_src       (pc_src),
        .o_target       (target),
        .o_stall        (stall)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .i_clk, .i_arst_n, .i_hold(1'b0), .i_bubble(stall), .i_d(id_d), .o_q(id_q)
    );

    execute_stage u_execute (.i_op(id_q), .i_wb(ex_q), .o_res(ex_d));

    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .i_clk, .i_arst_n, .i_hold(1'b0), .i_bubble(1'b0), .i_d(ex_d), .o_q(ex_q)
    );

endmodule

//--- mips_pkg.sv
package mips_pkg;

    localparam int XLEN = 32;
    localparam int NREG = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC = '0;

    // Primary opcodes, inst[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // R-type function codes, inst[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        word_t inst;
        word_t npc;                 // PC of the instruction plus 4
    } if_id_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        reg_idx_t src_a;            // rs, for forwarding in execute
        word_t    op_a;
        reg_idx_t src_b;            // rt
        word_t    op_b;
        logic     use_imm;
        word_t    imm;              // Already extended
        logic     reg_write;
        reg_idx_t dest;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t dest;
        word_t    result;
    } ex_wb_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t adr;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

endpackage

//--- pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_hold,                // Keep current contents
    input  logic     i_bubble,              // Load zeros, valid drops
    input  payload_t i_d,
    output payload_t o_q
);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_q <= '0;
        end else if (!i_hold) begin
            if (i_bubble) begin
                o_q <= '0;
            end else begin
                o_q <= i_d;
            end
        end
    end

    // A held stage cannot also take a bubble
    a_hold_xor_bubble : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        !(i_hold && i_bubble)
    );

endmodule

//--- register_file.sv
`timescale 1ns/1ns

module register_file import mips_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_we,
    input  reg_idx_t i_waddr,
    input  word_t    i_wdata,
    input  reg_idx_t i_raddr_a,
    input  reg_idx_t i_raddr_b,
    input  reg_idx_t i_dbg_addr,
    output word_t    o_rdata_a,
    output word_t    o_rdata_b,
    output word_t    o_dbg_data
);

    word_t regs [NREG];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin   // r0 stays zero
            regs[i_waddr] <= i_wdata;
        end
    end

    // Reads see the old value during a write cycle
    assign o_rdata_a  = regs[i_raddr_a];
    assign o_rdata_b  = regs[i_raddr_b];
    assign o_dbg_data = regs[i_dbg_addr];

endmodule

//--- tb_mips_core.sv
`timescale 1ns/1ns

module tb_mips_core import mips_pkg::*; ();

    localparam int RESET_CYCLES   = 5;
    localparam int RUN_CYCLES     = 200;    // Longest program with 3 wait states is ~110
    localparam int MEM_WORDS      = 256;
    // Eleven program runs of about 206 cycles, about 100 read cycles, then margin
    localparam int TIMEOUT_CYCLES = 3000;

    logic     clk;
    logic     arst_n;
    wb_s2m_t  wb_in;
    wb_m2s_t  wb_out;
    reg_idx_t dbg_addr;
    word_t    dbg_data;

    word_t    mem [MEM_WORDS];
    int       prog_idx;
    logic     wait_mode;                    // LFSR wait states when high
    logic [15:0] lfsr_q;
    int       waits_left;
    logic     busy;
    word_t    fetch_adrs [$];               // Address of every fetch started
    logic     stb_prev;
    string    cur_test;
    int       errors;
    int       errors_at_start;
    int       checks;
    int       tests_run;
    int       tests_failed;
    int       cycle_cnt = 0;

    mips_core dut (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_wb       (wb_in),
        .o_wb       (wb_out),
        .i_dbg_addr (dbg_addr),
        .o_dbg_data (dbg_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function logic next_lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // Wishbone classic slave, word addressed
    always @(posedge clk) begin
        #1;
        if (!arst_n || wb_in.ack) begin
            wb_in.ack = 1'b0;               // Ack lasts one cycle
            busy = 1'b0;
        end else if (wb_out.stb) begin
            if (!busy) begin
                busy = 1'b1;
                waits_left = 0;
                if (wait_mode) begin
                    waits_left = 2 * next_lfsr_bit();
                    waits_left += next_lfsr_bit();
                end
            end
            if (waits_left == 0) begin
                wb_in.ack = 1'b1;
                wb_in.dat = mem[wb_out.adr[9:2]];
            end else begin
                waits_left--;
            end
        end
    end

    function automatic word_t enc_r(logic [5:0] fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_idx_t rt, reg_idx_t rs,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(logic [25:0] idx);
        return {OP_J, idx};
    endfunction

    function automatic word_t sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t zext16(logic [15:0] v);
        return {16'h0000, v};
    endfunction

    function automatic word_t signed_less(word_t a, word_t b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    task automatic emit(word_t w);
        mem[prog_idx] = w;
        prog_idx++;
    endtask

    task automatic emit_spaced(word_t w, int gap);
        emit(w);
        repeat (gap) emit(32'h0000_0000);   // Unused funct, no write
    endtask

    // Small memory, so npc[31:28] is zero and the index is the word address
    task automatic emit_jump_self();
        emit(enc_j(26'(prog_idx)));
    endtask

    task automatic start_test(string name);
        cur_test = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", cur_test, errors - errors_at_start);
        end
    endtask

    task automatic load_start();
        int i;
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        wait_mode = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {6'h00, 12'h000, i[7:0], 6'h3f};   // Nop that carries its address
        end
        prog_idx = 0;
        fetch_adrs.delete();
        stb_prev = 1'b0;
    endtask

    task automatic release_reset(int held);
        repeat (held) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic run_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            if (wb_out.stb && !stb_prev) begin
                fetch_adrs.push_back(wb_out.adr);
            end
            stb_prev = wb_out.stb;
        end
    endtask

    task automatic run_program();
        release_reset(RESET_CYCLES);
        run_cycles(RUN_CYCLES);
    endtask

    task automatic read_reg(reg_idx_t idx, output word_t val);
        @(posedge clk);
        #1;
        dbg_addr = idx;
        #1;
        val = dbg_data;
    endtask

    task automatic check_word(string what, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bus(string what, wb_m2s_t exp, wb_m2s_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s %s: expected cyc=%b stb=%b adr=%h, actual cyc=%b stb=%b adr=%h",
                     cur_test, what, exp.cyc, exp.stb, exp.adr, act.cyc, act.stb, act.adr);
        end
    endtask

    task automatic check_reg(string tag, reg_idx_t idx, word_t exp);
        word_t v;
        read_reg(idx, v);
        check_word($sformatf("%s r%0d", tag, idx), exp, v);
    endtask

    task automatic reset_and_fetch();
        int i;
        start_test("reset_and_fetch");
        load_start();
        emit(enc_i(OP_ADDIU, 5'd0, 5'd0, 16'h0055));   // Write to r0 is dropped
        emit(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'h0007));
        emit_jump_self();
        @(posedge clk);
        #1;
        check_bus("bus in reset", '{cyc: 1'b0, stb: 1'b0, adr: RESET_PC}, wb_out);
        dbg_addr = 5'd1;
        #1;
        check_word("r1 in reset", '0, dbg_data);
        dbg_addr = 5'd31;
        #1;
        check_word("r31 in reset", '0, dbg_data);
        release_reset(RESET_CYCLES - 1);
        run_cycles(1);
        check_bus("first fetch", '{cyc: 1'b1, stb: 1'b1, adr: RESET_PC}, wb_out);
        run_cycles(RUN_CYCLES - 1);
        for (i = 0; i < 3; i++) begin
            check_word($sformatf("fetch %0d adr", i), RESET_PC + 4 * i, fetch_adrs[i]);
        end
        for (i = 0; i < NREG; i++) begin
            check_reg("final", reg_idx_t'(i), (i == 1) ? 32'd7 : 32'd0);
        end
        finish_test();
    endtask

    task automatic alu_independent();
        word_t exp [NREG];
        int    i;
        start_test("alu_independent");
        load_start();
        emit(enc_i(OP_LUI, 5'd1, 5'd0, 16'h8001));
        emit(enc_i(OP_ORI, 5'd1, 5'd1, 16'h2345));
        emit(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'hfff3));
        emit(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'h0123));
        emit(enc_r(FN_ADDU, 5'd4, 5'd1, 5'd2));
        emit(enc_r(FN_SUBU, 5'd5, 5'd3, 5'd1));
        emit(enc_r(FN_AND, 5'd6, 5'd1, 5'd2));
        emit(enc_r(FN_OR, 5'd7, 5'd1, 5'd3));
        emit(enc_r(FN_XOR, 5'd8, 5'd1, 5'd2));
        emit(enc_r(FN_SLT, 5'd9, 5'd1, 5'd3));
        emit(enc_r(FN_SLT, 5'd10, 5'd3, 5'd2));
        emit(enc_i(OP_ADDIU, 5'd11, 5'd3, 16'h8000));
        emit(enc_i(OP_ANDI, 5'd12, 5'd2, 16'hf0f3));
        emit(enc_i(OP_ORI, 5'd13, 5'd3, 16'h8000));
        emit(enc_i(OP_LUI, 5'd14, 5'd0, 16'hbeef));
        emit_jump_self();
        exp[1]  = {16'h8001, 16'h0000} | zext16(16'h2345);
        exp[2]  = sext16(16'hfff3);
        exp[3]  = sext16(16'h0123);
        exp[4]  = exp[1] + exp[2];          // Wraps at 32 bits
        exp[5]  = exp[3] - exp[1];
        exp[6]  = exp[1] & exp[2];
        exp[7]  = exp[1] | exp[3];
        exp[8]  = exp[1] ^ exp[2];
        exp[9]  = signed_less(exp[1], exp[3]);
        exp[10] = signed_less(exp[3], exp[2]);
        exp[11] = exp[3] + sext16(16'h8000);
        exp[12] = exp[2] & zext16(16'hf0f3);
        exp[13] = exp[3] | zext16(16'h8000);
        exp[14] = {16'hbeef, 16'h0000};
        run_program();
        for (i = 1; i <= 14; i++) begin
            check_reg("alu", reg_idx_t'(i), exp[i]);
        end
        finish_test();
    endtask

    task automatic load_chain(int gap);
        emit_spaced(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'd5), gap);
        emit_spaced(enc_r(FN_ADDU, 5'd2, 5'd1, 5'd1), gap);
        emit_spaced(enc_i(OP_ADDIU, 5'd3, 5'd2, 16'd3), gap);
        emit_spaced(enc_r(FN_SUBU, 5'd4, 5'd3, 5'd1), gap);
        emit_spaced(enc_r(FN_XOR, 5'd5, 5'd3, 5'd2), gap);  // Distance two on r3
        emit_spaced(enc_r(FN_SLT, 5'd6, 5'd4, 5'd3), gap);
        emit_spaced(enc_r(FN_OR, 5'd7, 5'd6, 5'd5), gap);
        emit_jump_self();
    endtask

    task automatic dependent_chains();
        word_t exp [NREG];
        word_t spaced [NREG];
        word_t v;
        int    i;
        start_test("dependent_chains");
        exp[1] = 32'd5;
        exp[2] = exp[1] + exp[1];
        exp[3] = exp[2] + sext16(16'd3);
        exp[4] = exp[3] - exp[1];
        exp[5] = exp[3] ^ exp[2];
        exp[6] = signed_less(exp[4], exp[3]);
        exp[7] = exp[6] | exp[5];
        load_start();
        load_chain(2);
        run_program();
        for (i = 1; i <= 7; i++) begin
            read_reg(reg_idx_t'(i), spaced[i]);
        end
        load_start();
        load_chain(0);
        run_program();
        for (i = 1; i <= 7; i++) begin
            read_reg(reg_idx_t'(i), v);
            check_word($sformatf("r%0d", i), exp[i], v);
            check_word($sformatf("r%0d vs spaced", i), spaced[i], v);
        end
        finish_test();
    endtask

    task automatic run_branch(string tag, logic use_bne, logic [15:0] r2_imm);
        logic  taken;
        word_t skipped;
        taken   = use_bne ? (r2_imm != 16'd9) : (r2_imm == 16'd9);
        skipped = taken ? 32'd0 : 32'd1;
        load_start();
        emit(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'd9));
        emit(enc_i(OP_ADDIU, 5'd2, 5'd0, r2_imm));      // Just before the branch
        emit(enc_i(use_bne ? OP_BNE : OP_BEQ, 5'd2, 5'd1, 16'd3));
        emit(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'd1));       // Delay slot
        emit(enc_i(OP_ADDIU, 5'd4, 5'd0, 16'd1));
        emit(enc_i(OP_ADDIU, 5'd5, 5'd0, 16'd1));
        emit(enc_i(OP_ADDIU, 5'd6, 5'd0, 16'd1));       // Target, npc + 12
        emit_jump_self();
        run_program();
        check_reg(tag, 5'd3, 32'd1);
        check_reg(tag, 5'd4, skipped);
        check_reg(tag, 5'd5, skipped);
        check_reg(tag, 5'd6, 32'd1);
    endtask

    task automatic branch_delay_slots();
        start_test("branch_delay_slots");
        run_branch("beq taken", 1'b0, 16'd9);
        run_branch("beq not taken", 1'b0, 16'd8);
        run_branch("bne taken", 1'b1, 16'd8);
        run_branch("bne not taken", 1'b1, 16'd9);
        finish_test();
    endtask

    task automatic jump_to_marker();
        word_t npc;
        word_t target;
        start_test("jump_to_marker");
        npc    = 32'd8;                     // J sits at 4
        target = {npc[31:28], 26'd16, 2'b00};
        load_start();
        emit(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'd1));
        emit(enc_j(26'd16));
        emit(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'd2));       // Delay slot
        emit(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'd3));       // Skipped
        prog_idx = target[9:2];
        emit(enc_i(OP_ORI, 5'd7, 5'd0, 16'habcd));      // Marker
        emit_jump_self();
        run_program();
        check_word("fetch after delay slot", target, fetch_adrs[3]);
        check_reg("jump", 5'd1, 32'd1);
        check_reg("jump", 5'd2, 32'd2);
        check_reg("jump", 5'd3, 32'd0);
        check_reg("jump", 5'd7, zext16(16'habcd));
        finish_test();
    endtask

    task automatic load_mixed();
        emit(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'd3));
        emit(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'd0));
        emit(enc_r(FN_ADDU, 5'd2, 5'd2, 5'd1));         // Loop head at 8
        emit(enc_i(OP_ADDIU, 5'd1, 5'd1, 16'hffff));
        emit(enc_i(OP_BNE, 5'd0, 5'd1, 16'hfffd));
        emit(enc_i(OP_ORI, 5'd3, 5'd3, 16'h0010));      // Delay slot on every pass
        emit(enc_r(FN_XOR, 5'd4, 5'd2, 5'd3));
        emit(enc_i(OP_LUI, 5'd5, 5'd0, 16'h1234));
        emit(enc_r(FN_SLT, 5'd6, 5'd5, 5'd4));
        emit(enc_j(26'd11));
        emit(enc_i(OP_ADDIU, 5'd7, 5'd0, 16'h0077));
        emit(enc_r(FN_SUBU, 5'd8, 5'd4, 5'd7));
        emit_jump_self();
    endtask

    task automatic wait_state_compare();
        word_t exp [NREG];
        word_t zero_wait [NREG];
        word_t v;
        int    i;
        start_test("wait_state_compare");
        exp[1] = 32'd3;
        exp[2] = 32'd0;
        repeat (3) begin
            exp[2] = exp[2] + exp[1];
            exp[1] = exp[1] + sext16(16'hffff);
        end
        exp[3] = zext16(16'h0010);
        exp[4] = exp[2] ^ exp[3];
        exp[5] = {16'h1234, 16'h0000};
        exp[6] = signed_less(exp[5], exp[4]);
        exp[7] = sext16(16'h0077);
        exp[8] = exp[4] - exp[7];
        load_start();
        load_mixed();
        run_program();
        for (i = 1; i <= 8; i++) begin
            read_reg(reg_idx_t'(i), zero_wait[i]);
            check_word($sformatf("zero wait r%0d", i), exp[i], zero_wait[i]);
        end
        load_start();
        load_mixed();
        wait_mode = 1'b1;
        lfsr_q = 16'd26143;
        run_program();
        for (i = 1; i <= 8; i++) begin
            read_reg(reg_idx_t'(i), v);
            check_word($sformatf("waits r%0d vs zero wait", i), zero_wait[i], v);
        end
        finish_test();
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        wb_in        = '0;
        dbg_addr     = '0;
        wait_mode    = 1'b0;
        lfsr_q       = 16'd26143;
        waits_left   = 0;
        busy         = 1'b0;
        stb_prev     = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset_and_fetch();
        alu_independent();
        dependent_chains();
        branch_delay_slots();
        jump_to_marker();
        wait_state_compare();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
